//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_BE_W   = 4;

    // OBI primary side
    typedef struct packed {
        logic                  req;
        logic [BUS_ADDR_W-1:0] addr;
        logic                  we;
        logic [BUS_BE_W-1:0]   be;
        logic [BUS_DATA_W-1:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [BUS_DATA_W-1:0] rdata;
    } obi_rsp_t;

    // Wishbone slave side
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [BUS_BE_W-1:0]   sel;
        logic [BUS_ADDR_W-1:0] adr;
        logic [BUS_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [BUS_DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- la_debug_port.sv
`timescale 1ns/1ps
`default_nettype none

module la_debug_port
    import bus_pkg::*, soc_pkg::*;
(
    input  logic [LA_W-1:0] la_i,

    // Observed buses
    input  obi_req_t        dmem_i,
    input  obi_rsp_t        dmem_rsp_i,
    input  obi_req_t        host_i,
    input  obi_rsp_t        host_rsp_i,
    input  obi_req_t        sram_i,
    input  obi_rsp_t        sram_rsp_i,

    // Decoded controls
    output logic            soft_reset_o,
    output logic            host_enable_o,

    output logic [LA_W-1:0] la_o
);

    la_channel_e channel;
    obi_req_t    smp_req;
    obi_rsp_t    smp_rsp;
    logic        smp_valid;

    ////////////////////
    // Control fields
    ////////////////////

    assign soft_reset_o  = (la_i[3:0] == LA_KEY);
    assign host_enable_o = (la_i[7:4] == LA_KEY);
    assign channel       = la_channel_e'(la_i[14:12]);

    ////////////////////
    // Channel select
    ////////////////////

    always_comb begin
        smp_req   = dmem_i;
        smp_rsp   = dmem_rsp_i;
        smp_valid = 1'b1;
        case (channel)
            LA_DMEM: begin
                smp_req = dmem_i;
                smp_rsp = dmem_rsp_i;
            end
            LA_HOST: begin
                smp_req = host_i;
                smp_rsp = host_rsp_i;
            end
            LA_SRAM: begin
                smp_req = sram_i;
                smp_rsp = sram_rsp_i;
            end
            // Unused channels read back as idle high
            default: begin
                smp_valid = 1'b0;
            end
        endcase
    end

    // Same bit layout for every bus channel
    always_comb begin
        la_o = '1;
        if (smp_valid) begin
            la_o[47:16]  = smp_req.addr;
            la_o[48]     = smp_req.req;
            la_o[49]     = smp_rsp.gnt;
            la_o[50]     = smp_req.we;
            la_o[54:51]  = smp_req.be;
            la_o[55]     = smp_rsp.rvalid;
            la_o[87:56]  = smp_rsp.rdata;
            la_o[119:88] = smp_req.wdata;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_soc -f sim.f -o tb_soc_sim \
    && ./obj_dir/tb_soc_sim | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0

//--- sim.f
+incdir+.
bus_pkg.sv
soc_pkg.sv
wb_host_bridge.sv
sram_arbiter.sv
soc_sram.sv
la_debug_port.sv
soc_top.sv
tb_soc.sv

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

    ////////////////////
    // Memory map
    ////////////////////

    localparam logic [31:0] SRAM_BASE     = 32'h8000_0000;

    // Host window folded onto the SRAM
    localparam logic [31:0] HOST_REMAP_LO = 32'h3000_0000;
    localparam logic [31:0] HOST_REMAP_HI = 32'h8000_0000;
    localparam logic [3:0]  REMAP_NIBBLE  = 4'h8;

    ////////////////////
    // Logic analyzer
    ////////////////////

    localparam int          LA_W   = 128;

    // Control field is active only when it holds this key
    localparam logic [3:0]  LA_KEY = 4'hA;

    // Sample channel select, bits 14:12
    typedef enum logic [2:0] {
        LA_DMEM = 3'd0,
        LA_HOST = 3'd1,
        LA_SRAM = 3'd2
    } la_channel_e;

    ////////////////////
    // Host bridge FSM
    ////////////////////

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_WAIT,
        WB_ACK
    } wb_state_e;

endpackage

`default_nettype wire

//--- soc_sram.sv
`timescale 1ns/1ps
`default_nettype none

module soc_sram
    import bus_pkg::*, soc_pkg::*;
#(
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  obi_req_t req_i,
    output obi_rsp_t rsp_o,
    output logic     illegal_o
);

    localparam int                    IDX_W      = $clog2(SRAM_WORDS);
    localparam logic [BUS_ADDR_W-1:0] SRAM_BYTES = BUS_ADDR_W'(4 * SRAM_WORDS);

    logic [BUS_DATA_W-1:0] mem [SRAM_WORDS];
    logic [BUS_ADDR_W-1:0] offset;
    logic [IDX_W-1:0]      idx;
    logic                  in_window;
    logic                  rvalid_q;
    logic                  illegal_q;
    logic [BUS_DATA_W-1:0] rdata_q;

    // Addresses below the base wrap to a large offset and fall outside
    assign offset    = req_i.addr - SRAM_BASE;
    assign in_window = offset < SRAM_BYTES;
    assign idx       = offset[IDX_W+1:2];

    // Never stalls
    assign rsp_o.gnt = req_i.req;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (req_i.req && req_i.we && in_window) begin
            for (int b = 0; b < BUS_BE_W; b++) begin
                if (req_i.be[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Writes and stray accesses answer with zero
    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (!req_i.we && in_window) begin
                rdata_q <= mem[idx];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    ////////////////////
    // Response
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            rvalid_q  <= req_i.req;
            illegal_q <= req_i.req && !in_window;
        end
    end

    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;
    assign illegal_o    = illegal_q;

endmodule

`default_nettype wire

//--- soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top
    import bus_pkg::*, soc_pkg::*;
#(
    parameter int unsigned           SRAM_WORDS    = 1024,
    parameter logic [BUS_ADDR_W-1:0] DOORBELL_ADDR = 32'h8000_0FFC
) (
    input  logic            clk_i,
    input  logic            reset_i,

    // Wishbone host port
    input  wb_req_t         host_i,
    output wb_rsp_t         host_o,

    // Core data port
    input  obi_req_t        dmem_i,
    output obi_rsp_t        dmem_o,

    // Logic analyzer
    input  logic [LA_W-1:0] la_data_i,
    output logic [LA_W-1:0] la_data_o,

    output logic [2:0]      irq_o
);

    logic     soc_reset;
    logic     soft_reset;
    logic     host_enable;
    logic     sram_illegal;
    logic     doorbell_hit;

    obi_req_t host_req;
    obi_rsp_t host_rsp;
    obi_req_t sram_req;
    obi_rsp_t sram_rsp;

    // Hard reset or the soft reset field
    assign soc_reset = reset_i || soft_reset;

    ////////////////////
    // Memory path
    ////////////////////

    wb_host_bridge u_host_bridge (
        .clk_i   (clk_i),
        .reset_i (soc_reset),
        .wb_i    (host_i),
        .wb_o    (host_o),
        .obi_o   (host_req),
        .obi_i   (host_rsp)
    );

    // Host is primary, data port secondary
    sram_arbiter u_sram_arbiter (
        .clk_i         (clk_i),
        .reset_i       (soc_reset),
        .host_enable_i (host_enable),
        .pri_i         (host_req),
        .pri_o         (host_rsp),
        .sec_i         (dmem_i),
        .sec_o         (dmem_o),
        .shr_o         (sram_req),
        .shr_i         (sram_rsp)
    );

    soc_sram #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram (
        .clk_i     (clk_i),
        .reset_i   (soc_reset),
        .req_i     (sram_req),
        .rsp_o     (sram_rsp),
        .illegal_o (sram_illegal)
    );

    ////////////////////
    // Debug and interrupts
    ////////////////////

    la_debug_port u_la_debug_port (
        .la_i          (la_data_i),
        .dmem_i        (dmem_i),
        .dmem_rsp_i    (dmem_o),
        .host_i        (host_req),
        .host_rsp_i    (host_rsp),
        .sram_i        (sram_req),
        .sram_rsp_i    (sram_rsp),
        .soft_reset_o  (soft_reset),
        .host_enable_o (host_enable),
        .la_o          (la_data_o)
    );

    // Doorbell follows the raw request, granted or not
    assign doorbell_hit = dmem_i.req && dmem_i.we && (dmem_i.addr == DOORBELL_ADDR);

    assign irq_o[2:1] = doorbell_hit ? dmem_i.wdata[1:0] : 2'b00;
    assign irq_o[0]   = sram_illegal;

endmodule

`default_nettype wire

//--- sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter
    import bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     host_enable_i,

    // Primary requester, the host
    input  obi_req_t pri_i,
    output obi_rsp_t pri_o,

    // Secondary requester, the data port
    input  obi_req_t sec_i,
    output obi_rsp_t sec_o,

    // Shared port toward the SRAM
    output obi_req_t shr_o,
    input  obi_rsp_t shr_i
);

    logic pri_win;
    logic sec_win;
    logic owner_q;

    ////////////////////
    // Fixed priority
    ////////////////////

    // Nobody wins while reset is held, so no grant leaks out
    assign pri_win = pri_i.req && host_enable_i && !reset_i;
    assign sec_win = sec_i.req && !pri_win && !reset_i;

    always_comb begin
        if (pri_win) begin
            shr_o = pri_i;
        end else begin
            shr_o = sec_i;
        end
        shr_o.req = pri_win || sec_win;
    end

    // Losers see no grant and keep holding their request
    assign pri_o.gnt = pri_win && shr_i.gnt;
    assign sec_o.gnt = sec_win && shr_i.gnt;

    ////////////////////
    // Response routing
    ////////////////////

    // Owner of the transfer in flight, one cycle behind the grant
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            owner_q <= 1'b0;
        end else if (shr_o.req && shr_i.gnt) begin
            owner_q <= pri_win;
        end
    end

    assign pri_o.rvalid = shr_i.rvalid && owner_q;
    assign sec_o.rvalid = shr_i.rvalid && !owner_q;

    // Read data is only meaningful alongside rvalid
    assign pri_o.rdata  = shr_i.rdata;
    assign sec_o.rdata  = shr_i.rdata;

endmodule

`default_nettype wire

//--- soc_tests.svh
`default_nettype none

// Random in-window word address
function automatic logic [31:0] random_offset();
    logic [31:0] rnd;
    rnd = $random(seed);
    return (rnd % SRAM_WORDS) << 2;
endfunction

task automatic test_dmem_random();
    logic [31:0] addr;
    logic [31:0] rnd;
    for (int i = 0; i < 16; i++) begin
        addr = SRAM_BASE + random_offset();
        // Full word first so partial writes merge into known data
        if (!model.exists(addr)) dmem_write(addr, 4'hF, $random(seed));
        rnd = $random(seed);
        dmem_write(addr, rnd[3:0], $random(seed));
    end
    verify_model("dmem_random");
endtask

task automatic test_host_remap();
    logic [31:0] offset;
    logic [31:0] data;
    logic [31:0] readback;
    offset = random_offset();
    data = $random(seed);
    @(negedge clk_i);
    la_ctrl[7:4] = LA_KEY;
    wb_write(HOST_REMAP_LO + offset, data);
    model_store(SRAM_BASE + offset, 4'hF, data);
    dmem_read(SRAM_BASE + offset, readback);
    check_value("host_remap_dmem", data, readback);
    wb_read(HOST_REMAP_LO + offset, readback);
    check_value("host_remap_wb", data, readback);
endtask

task automatic test_host_gate();
    logic [31:0] offset;
    logic [31:0] data;
    logic [31:0] readback;
    logic        acked;
    offset = random_offset();
    data = $random(seed);
    @(negedge clk_i);
    la_ctrl[7:4] = 4'h0;
    wb_start(1'b1, HOST_REMAP_LO + offset, data);
    wb_wait_ack(30, acked, readback);
    check_value("host_gate_no_ack", 32'd0, {31'd0, acked});
    // Data port keeps running while the host stalls
    dmem_write(SRAM_BASE + random_offset(), 4'hF, $random(seed));
    verify_model("host_gate_dmem");
    @(negedge clk_i);
    la_ctrl[7:4] = LA_KEY;
    wb_finish(readback);
    model_store(SRAM_BASE + offset, 4'hF, data);
    dmem_read(SRAM_BASE + offset, readback);
    check_value("host_gate_visible", data, readback);
endtask

task automatic test_illegal_access();
    logic [31:0] data;
    // Words that the stray addresses below would alias onto
    dmem_write(SRAM_BASE, 4'hF, 32'hC3C3_3C3C);
    dmem_write(SRAM_BASE + 4 * SRAM_WORDS - 4, 4'hF, 32'h9669_6996);
    dmem_read(SRAM_BASE + 4 * SRAM_WORDS, data);
    check_value("illegal_read_data", 32'h0, data);
    check_value("illegal_read_irq", 32'd1, {31'd0, rsp_illegal});
    dmem_write(SRAM_BASE + 4 * SRAM_WORDS, 4'hF, $random(seed));
    dmem_write(SRAM_BASE - 32'd4, 4'hF, $random(seed));
    verify_model("illegal_write_model");
endtask

task automatic test_doorbell();
    logic [31:0] data;
    logic [31:0] unused;
    data = $random(seed);
    data[1:0] = 2'b10;
    dmem_drive(1'b1, DOORBELL_ADDR, 4'hF, data);
    #(SAMPLE_DELAY);
    check_value("doorbell_irq", {30'd0, data[1:0]}, {30'd0, irq[2:1]});
    dmem_finish(unused);
    model_store(DOORBELL_ADDR, 4'hF, data);
endtask

task automatic test_la_debug();
    logic [31:0] addr;
    logic [31:0] unused;
    addr = SRAM_BASE + random_offset();
    // Known word that the blocked write must leave alone
    dmem_write(addr, 4'hF, 32'hA5A5_5A5A);
    @(negedge clk_i);
    la_ctrl[14:12] = LA_DMEM;
    dmem_drive(1'b0, addr, 4'hF, 32'h0);
    #(SAMPLE_DELAY);
    check_value("la_dmem_addr", addr, la_sample[47:16]);
    check_value("la_dmem_low", 32'h0000_FFFF, {16'h0, la_sample[15:0]});
    dmem_finish(unused);
    @(negedge clk_i);
    la_ctrl[14:12] = 3'd5;
    #(SAMPLE_DELAY);
    check_value("la_idle_channel", 32'd1, {31'd0, &la_sample[127:16]});
    // Soft reset holds off every grant
    @(negedge clk_i);
    la_ctrl[3:0] = LA_KEY;
    dmem_drive(1'b1, addr, 4'hF, 32'h5A5A_A5A5);
    repeat (4) begin
        @(posedge clk_i);
        check_value("soft_reset_gnt", 32'd0, {31'd0, dmem_rsp.gnt});
    end
    @(negedge clk_i);
    dmem_req = '0;
    la_ctrl[3:0] = 4'h0;
    verify_model("soft_reset_contents");
endtask

`default_nettype wire

//--- tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc
    import bus_pkg::*, soc_pkg::*;
();

    localparam int unsigned SRAM_WORDS    = 1024;
    localparam logic [31:0] DOORBELL_ADDR = 32'h8000_0FFC;
    localparam int          HALF_PERIOD   = 20;
    localparam int          SAMPLE_DELAY  = 5;
    localparam int          TIMEOUT       = 200;

    logic            clk_i = 1'b0;
    logic            reset_i;
    wb_req_t         host_req;
    wb_rsp_t         host_rsp;
    obi_req_t        dmem_req;
    obi_rsp_t        dmem_rsp;
    logic [LA_W-1:0] la_ctrl;
    logic [LA_W-1:0] la_sample;
    logic [2:0]      irq;

    // Reference SRAM contents keyed by byte address
    logic [31:0]     model [logic [31:0]];
    integer          seed = 32'h9c59_4f5e;
    logic            rsp_illegal = 1'b0;

    always #(HALF_PERIOD) clk_i = ~clk_i;

    soc_top #(
        .SRAM_WORDS    (SRAM_WORDS),
        .DOORBELL_ADDR (DOORBELL_ADDR)
    ) DUT (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .host_i    (host_req),
        .host_o    (host_rsp),
        .dmem_i    (dmem_req),
        .dmem_o    (dmem_rsp),
        .la_data_i (la_ctrl),
        .la_data_o (la_sample),
        .irq_o     (irq)
    );

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    ////////////////////
    // SRAM model
    ////////////////////

    function automatic void model_store(input logic [31:0] addr, input logic [3:0] be,
                                        input logic [31:0] data);
        logic [31:0] word;
        // Stray addresses never reach the array
        if (addr >= SRAM_BASE && addr < SRAM_BASE + 4 * SRAM_WORDS) begin
            word = model.exists(addr) ? model[addr] : 32'h0;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    word[8*b +: 8] = data[8*b +: 8];
                end
            end
            model[addr] = word;
        end
    endfunction

    ////////////////////
    // Data port tasks
    ////////////////////

    task automatic dmem_drive(input logic we, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        @(negedge clk_i);
        dmem_req = '{req: 1'b1, addr: addr, we: we, be: be, wdata: wdata};
    endtask

    // Waits for the grant, drops the request, then waits for rvalid
    task automatic dmem_finish(output logic [31:0] rdata);
        int   cycles;
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(posedge clk_i);
            seen = dmem_rsp.gnt;
            cycles++;
            if (!seen && cycles >= TIMEOUT) timeout_fail("data port grant never arrived");
        end
        @(negedge clk_i);
        dmem_req = '0;
        seen = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(posedge clk_i);
            seen = dmem_rsp.rvalid;
            cycles++;
            if (!seen && cycles >= TIMEOUT) timeout_fail("data port rvalid never arrived");
        end
        rdata = dmem_rsp.rdata;
        rsp_illegal = irq[0];
    endtask

    task automatic dmem_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [31:0] unused;
        dmem_drive(1'b1, addr, be, data);
        dmem_finish(unused);
        model_store(addr, be, data);
    endtask

    task automatic dmem_read(input logic [31:0] addr, output logic [31:0] data);
        dmem_drive(1'b0, addr, 4'hF, 32'h0);
        dmem_finish(data);
    endtask

    task automatic verify_model(input string name);
        logic [31:0] data;
        foreach (model[a]) begin
            dmem_read(a, data);
            check_value(name, model[a], data);
        end
    endtask

    ////////////////////
    // Wishbone tasks
    ////////////////////

    task automatic wb_start(input logic we, input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_i);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: 4'hF, adr: addr, dat: data};
    endtask

    task automatic wb_wait_ack(input int limit, output logic acked, output logic [31:0] rdata);
        int cycles;
        acked = 1'b0;
        cycles = 0;
        while (!acked && cycles < limit) begin
            @(posedge clk_i);
            acked = host_rsp.ack;
            cycles++;
        end
        rdata = host_rsp.dat;
    endtask

    task automatic wb_finish(output logic [31:0] rdata);
        logic acked;
        wb_wait_ack(TIMEOUT, acked, rdata);
        if (!acked) timeout_fail("Wishbone ack never arrived");
        @(negedge clk_i);
        host_req = '0;
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        wb_start(1'b1, addr, data);
        wb_finish(unused);
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
        wb_start(1'b0, addr, 32'h0);
        wb_finish(data);
    endtask

    `include "soc_tests.svh"

    initial begin
        reset_i  = 1'b1;
        host_req = '0;
        dmem_req = '0;
        la_ctrl  = '0;
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;

        test_dmem_random();
        test_host_remap();
        test_host_gate();
        test_illegal_access();
        test_doorbell();
        test_la_debug();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_host_bridge
    import bus_pkg::*, soc_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,

    // Wishbone slave port from the host
    input  wb_req_t  wb_i,
    output wb_rsp_t  wb_o,

    // OBI primary port toward the arbiter
    output obi_req_t obi_o,
    input  obi_rsp_t obi_i
);

    wb_state_e             state_q;
    wb_state_e             state_d;
    logic [BUS_DATA_W-1:0] rdata_q;
    logic [BUS_ADDR_W-1:0] host_addr;

    ////////////////////
    // Address remap
    ////////////////////

    always_comb begin
        if (wb_i.adr >= HOST_REMAP_LO && wb_i.adr < HOST_REMAP_HI) begin
            host_addr = {REMAP_NIBBLE, wb_i.adr[BUS_ADDR_W-5:0]};
        end else begin
            host_addr = wb_i.adr;
        end
    end

    ////////////////////
    // Cycle FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                if (wb_i.cyc && wb_i.stb) begin
                    state_d = WB_REQ;
                end
            end
            // Request stays up until the arbiter grants it
            WB_REQ: begin
                if (obi_i.gnt) begin
                    state_d = WB_WAIT;
                end
            end
            WB_WAIT: begin
                if (obi_i.rvalid) begin
                    state_d = WB_ACK;
                end
            end
            WB_ACK: begin
                state_d = WB_IDLE;
            end
            default: begin
                state_d = WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Read data held for the ack cycle
    always_ff @(posedge clk_i) begin
        if (state_q == WB_WAIT && obi_i.rvalid) begin
            rdata_q <= obi_i.rdata;
        end
    end

    // Master keeps its fields stable until ack, so they pass straight on
    assign obi_o.req   = (state_q == WB_REQ);
    assign obi_o.addr  = host_addr;
    assign obi_o.we    = wb_i.we;
    assign obi_o.be    = wb_i.sel;
    assign obi_o.wdata = wb_i.dat;

    assign wb_o.ack    = (state_q == WB_ACK);
    assign wb_o.dat    = rdata_q;

endmodule

`default_nettype wire
